// ==== logic/sd_init_defs.svh ====
// timing and sizing macros for the SD bring-up design, included by the top and the testbench
`ifndef SD_INIT_DEFS_SVH
`define SD_INIT_DEFS_SVH

// ====================
// SD clock
// ====================

// system clocks per sd_clk half period
// 50 MHz / 250 / 2 gives the 100 kHz identification clock
`define SD_CLK_HALF 250

// idle clocks with cmd high before CMD0
// the card needs at least 74
`define SD_IDLE_CLOCKS 80

// ====================
// status path
// ====================

// system clocks per serial bit, about 115200 baud at 50 MHz
`define UART_BAUD_DIV 434

// two entries, so the transmitter really stalls the sequencer
`define STATUS_FIFO_DEPTH 2

`endif

// ==== logic/sd_init_pkg.sv ====
// shared types and command constants for the SD bring-up design, imported by the RTL and testbench
package sd_init_pkg;

    // ====================
    // field types
    // ====================

    // command index, six bits after start and transmission bits
    typedef logic [5:0] sd_index_t;
    // command argument
    typedef logic [31:0] sd_arg_t;
    // x^7 + x^3 + 1 checksum
    typedef logic [6:0] crc7_t;
    // one ascii status character
    typedef logic [7:0] status_char_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE_CLOCKS,
        SEND_CMD,
        WAIT_CMD,
        PUSH_CHAR,
        DONE
    } seq_state_t;

    // ====================
    // command set
    // ====================

    // GO_IDLE_STATE
    localparam sd_index_t SD_CMD0   = 6'd0;
    // APP_CMD, prefix for the next command
    localparam sd_index_t SD_CMD55  = 6'd55;
    // SD_SEND_OP_COND
    localparam sd_index_t SD_ACMD41 = 6'd41;
    // HCS bit set, host supports high capacity
    localparam sd_arg_t ACMD41_ARG = 32'h4000_0000;

endpackage

// ==== logic/sd_cmd_tx.sv ====
// SD command line shifter: slow clock, idle clocks and one 48-bit frame with CRC7 per request
`timescale 1ns/100ps
`include "sd_init_defs.svh"

module sd_cmd_tx #(
    parameter int CLK_HALF = 250
) (
    input  logic                   CLOCK_50,
    input  logic                   reset_n,
    input  logic                   idle_valid,
    input  logic                   cmd_valid,
    input  sd_init_pkg::sd_index_t cmd_index,
    input  sd_init_pkg::sd_arg_t   cmd_arg,
    output logic                   cmd_ready,
    output logic                   cmd_done,
    output logic                   sd_clk,
    output logic                   sd_cmd_out,
    output logic                   sd_cmd_oe
);
    import sd_init_pkg::*;

    localparam int DIV_W = $clog2(CLK_HALF + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_HALF - 1);
    localparam int MAX_BITS = (`SD_IDLE_CLOCKS > 48) ? `SD_IDLE_CLOCKS : 48;
    localparam int CNT_W = $clog2(MAX_BITS);
    localparam logic [CNT_W-1:0] IDLE_LAST    = CNT_W'(`SD_IDLE_CLOCKS - 1);
    localparam logic [CNT_W-1:0] PAYLOAD_LAST = CNT_W'(39);
    localparam logic [CNT_W-1:0] CRC_LAST     = CNT_W'(45);
    localparam logic [CNT_W-1:0] FRAME_LAST   = CNT_W'(47);

    logic             busy;
    logic             is_idle;
    logic [DIV_W-1:0] div_cnt;
    logic [CNT_W-1:0] bit_cnt;
    logic [39:0]      sr;
    crc7_t            crc;
    crc7_t            crc_n;
    logic             fb;
    logic             next_bit;
    logic             start;
    logic             half_tick;
    logic             fall;
    logic [CNT_W-1:0] last_bit;

    assign cmd_ready = !busy;
    assign start     = cmd_ready && (cmd_valid || idle_valid);
    assign half_tick = busy && (div_cnt == DIV_LAST);
    // outgoing bit changes here, card samples on the rise
    assign fall      = half_tick && sd_clk;
    assign last_bit  = is_idle ? IDLE_LAST : FRAME_LAST;

    // ====================
    // CRC7 and bit select
    // ====================

    // serial crc, sr[39] is the bit on the line
    always_comb begin
        fb    = crc[6] ^ sr[39];
        crc_n = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    end

    // bit for the next sd_clk period
    always_comb begin
        if (bit_cnt < PAYLOAD_LAST) begin
            next_bit = sr[38];
        end else if (bit_cnt == PAYLOAD_LAST) begin
            // crc msb before it lands in the register
            next_bit = crc_n[6];
        end else if (bit_cnt <= CRC_LAST) begin
            next_bit = crc[5];
        end else begin
            // end bit
            next_bit = 1'b1;
        end
    end

    // frame payload and checksum
    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            sr  <= {1'b0, 1'b1, cmd_index, cmd_arg};
            crc <= '0;
        end else if (fall && !is_idle) begin
            sr <= {sr[38:0], 1'b1};
            if (bit_cnt <= PAYLOAD_LAST) begin
                crc <= crc_n;
            end else begin
                // crc now shifts out msb first
                crc <= {crc[5:0], 1'b0};
            end
        end
    end

    // ====================
    // clock and line control
    // ====================

    always_ff @(posedge CLOCK_50 or negedge reset_n) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            is_idle    <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            sd_clk     <= 1'b0;
            sd_cmd_out <= 1'b1;
            sd_cmd_oe  <= 1'b0;
            cmd_done   <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (start) begin
                busy       <= 1'b1;
                is_idle    <= idle_valid;
                div_cnt    <= '0;
                bit_cnt    <= '0;
                sd_cmd_oe  <= 1'b1;
                // idle clocks hold the line high, a frame opens with start 0
                sd_cmd_out <= idle_valid;
            end else if (half_tick) begin
                div_cnt <= '0;
                sd_clk  <= !sd_clk;
                if (fall) begin
                    if (bit_cnt == last_bit) begin
                        // last period done, release the line
                        busy       <= 1'b0;
                        sd_cmd_oe  <= 1'b0;
                        sd_cmd_out <= 1'b1;
                        cmd_done   <= 1'b1;
                    end else begin
                        bit_cnt    <= bit_cnt + 1'b1;
                        sd_cmd_out <= is_idle ? 1'b1 : next_bit;
                    end
                end
            end else if (busy) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // the sequencer offers one kind of request at a time
    a_one_request: assert property (@(posedge CLOCK_50) disable iff (!reset_n)
        !(cmd_valid && idle_valid));

endmodule

// ==== logic/sd_init_seq.sv ====
// SD bring-up sequencer: idle clocks, CMD0, CMD55, ACMD41, with a status character after each
`timescale 1ns/100ps

module sd_init_seq (
    input  logic                      CLOCK_50,
    input  logic                      reset_n,
    input  logic                      cmd_ready,
    input  logic                      cmd_done,
    input  logic                      char_ready,
    output logic                      idle_valid,
    output logic                      cmd_valid,
    output sd_init_pkg::sd_index_t    cmd_index,
    output sd_init_pkg::sd_arg_t      cmd_arg,
    output logic                      char_valid,
    output sd_init_pkg::status_char_t char_data,
    output logic                      init_done
);
    import sd_init_pkg::*;

    // step through the bring-up, one per command plus the final 'D'
    localparam logic [2:0] STEP_IDLE   = 3'd0;
    localparam logic [2:0] STEP_CMD0   = 3'd1;
    localparam logic [2:0] STEP_CMD55  = 3'd2;
    localparam logic [2:0] STEP_ACMD41 = 3'd3;
    localparam logic [2:0] STEP_FINAL  = 3'd4;

    seq_state_t state;
    logic [2:0] step;

    // requests come straight from the state, so they hold while stalled
    assign idle_valid = (state == IDLE_CLOCKS);
    assign cmd_valid  = (state == SEND_CMD);
    assign char_valid = (state == PUSH_CHAR);

    // ====================
    // per-step contents
    // ====================

    always_comb begin
        cmd_index = SD_CMD0;
        cmd_arg   = '0;
        char_data = "D";
        case (step)
            STEP_CMD0: begin
                char_data = "0";
            end
            STEP_CMD55: begin
                cmd_index = SD_CMD55;
                char_data = "5";
            end
            STEP_ACMD41: begin
                cmd_index = SD_ACMD41;
                cmd_arg   = ACMD41_ARG;
                char_data = "A";
            end
            default: begin
                // idle and final step carry no command
                cmd_index = SD_CMD0;
            end
        endcase
    end

    // ====================
    // state machine
    // ====================

    always_ff @(posedge CLOCK_50 or negedge reset_n) begin
        if (!reset_n) begin
            state     <= IDLE_CLOCKS;
            step      <= STEP_IDLE;
            init_done <= 1'b0;
        end else begin
            case (state)
                IDLE_CLOCKS: begin
                    if (cmd_ready) begin
                        state <= WAIT_CMD;
                    end
                end
                SEND_CMD: begin
                    if (cmd_ready) begin
                        state <= WAIT_CMD;
                    end
                end
                WAIT_CMD: begin
                    if (cmd_done) begin
                        if (step == STEP_IDLE) begin
                            // no character for the idle clocks
                            step  <= STEP_CMD0;
                            state <= SEND_CMD;
                        end else begin
                            state <= PUSH_CHAR;
                        end
                    end
                end
                PUSH_CHAR: begin
                    if (char_ready) begin
                        if (step == STEP_FINAL) begin
                            state     <= DONE;
                            init_done <= 1'b1;
                        end else if (step == STEP_ACMD41) begin
                            // 'D' follows 'A' directly
                            step <= STEP_FINAL;
                        end else begin
                            step  <= step + 1'b1;
                            state <= SEND_CMD;
                        end
                    end
                end
                DONE: begin
                    state <= DONE;
                end
                default: begin
                    state <= IDLE_CLOCKS;
                end
            endcase
        end
    end

    // a stalled character waits unchanged for the FIFO
    a_char_hold: assert property (@(posedge CLOCK_50) disable iff (!reset_n)
        char_valid && !char_ready |=> char_valid && $stable(char_data));

endmodule

// ==== logic/status_fifo.sv ====
// small valid/ready FIFO that buffers status characters between sequencer and transmitter
`timescale 1ns/100ps

module status_fifo #(
    parameter int DEPTH = 2
) (
    input  logic                      CLOCK_50,
    input  logic                      reset_n,
    input  logic                      in_valid,
    input  sd_init_pkg::status_char_t in_data,
    input  logic                      out_ready,
    output logic                      in_ready,
    output logic                      out_valid,
    output sd_init_pkg::status_char_t out_data
);
    import sd_init_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    status_char_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_FULL);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // storage
    always_ff @(posedge CLOCK_50) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at DEPTH and count tracks occupancy
    always_ff @(posedge CLOCK_50 or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // full means writes have come round to the read pointer
    a_no_push_full: assert property (@(posedge CLOCK_50) disable iff (!reset_n)
        (count == CNT_FULL) |-> (wr_ptr == rd_ptr));
    // empty means reads have caught up with writes
    a_no_pop_empty: assert property (@(posedge CLOCK_50) disable iff (!reset_n)
        (count == '0) |-> (wr_ptr == rd_ptr));

endmodule

// ==== logic/uart_tx.sv ====
// 8N1 serial transmitter that drains status characters, one frame per handshake
`timescale 1ns/100ps

module uart_tx #(
    parameter int BAUD_DIV = 434
) (
    input  logic                      CLOCK_50,
    input  logic                      reset_n,
    input  logic                      in_valid,
    input  sd_init_pkg::status_char_t in_data,
    output logic                      in_ready,
    output logic                      txd
);

    localparam int BAUD_W = $clog2(BAUD_DIV + 1);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);

    logic              busy;
    logic [9:0]        frame;
    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    logic              bit_tick;

    // idle means ready for the next character
    assign in_ready = !busy;
    // lsb of the frame is on the wire
    assign txd      = frame[0];
    assign bit_tick = busy && (baud_cnt == BAUD_LAST);

    // ====================
    // shifter
    // ====================

    always_ff @(posedge CLOCK_50 or negedge reset_n) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            frame    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (in_valid && in_ready) begin
                // stop, data lsb first, start
                frame    <= {1'b1, in_data, 1'b0};
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end else if (bit_tick) begin
                baud_cnt <= '0;
                // refill with ones so the line idles high
                frame    <= {1'b1, frame[9:1]};
                if (bit_cnt == 4'd9) begin
                    // stop bit finished
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (busy) begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/sd_init_top.sv ====
// top level of the SD bring-up: sequencer, command shifter, status FIFO and serial transmitter
`timescale 1ns/100ps
`include "sd_init_defs.svh"

module sd_init_top #(
    parameter int SD_CLK_HALF_P = `SD_CLK_HALF,
    parameter int BAUD_DIV_P    = `UART_BAUD_DIV
) (
    input  logic CLOCK_50,
    input  logic reset_n,
    output logic sd_clk,
    output logic sd_cmd_out,
    output logic sd_cmd_oe,
    output logic uart_txd,
    output logic init_done
);
    import sd_init_pkg::*;

    // sequencer to shifter
    logic         idle_valid;
    logic         cmd_valid;
    logic         cmd_ready;
    logic         cmd_done;
    sd_index_t    cmd_index;
    sd_arg_t      cmd_arg;
    // sequencer to FIFO
    logic         char_valid;
    logic         char_ready;
    status_char_t char_data;
    // FIFO to transmitter
    logic         out_valid;
    logic         out_ready;
    status_char_t out_data;

    // ====================
    // producer side
    // ====================

    sd_init_seq u_seq (
        .CLOCK_50   (CLOCK_50),
        .reset_n    (reset_n),
        .cmd_ready  (cmd_ready),
        .cmd_done   (cmd_done),
        .char_ready (char_ready),
        .idle_valid (idle_valid),
        .cmd_valid  (cmd_valid),
        .cmd_index  (cmd_index),
        .cmd_arg    (cmd_arg),
        .char_valid (char_valid),
        .char_data  (char_data),
        .init_done  (init_done)
    );

    sd_cmd_tx #(
        .CLK_HALF (SD_CLK_HALF_P)
    ) u_cmd_tx (
        .CLOCK_50   (CLOCK_50),
        .reset_n    (reset_n),
        .idle_valid (idle_valid),
        .cmd_valid  (cmd_valid),
        .cmd_index  (cmd_index),
        .cmd_arg    (cmd_arg),
        .cmd_ready  (cmd_ready),
        .cmd_done   (cmd_done),
        .sd_clk     (sd_clk),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe)
    );

    // ====================
    // status path
    // ====================

    status_fifo #(
        .DEPTH (`STATUS_FIFO_DEPTH)
    ) u_fifo (
        .CLOCK_50  (CLOCK_50),
        .reset_n   (reset_n),
        .in_valid  (char_valid),
        .in_data   (char_data),
        .out_ready (out_ready),
        .in_ready  (char_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    uart_tx #(
        .BAUD_DIV (BAUD_DIV_P)
    ) u_uart (
        .CLOCK_50 (CLOCK_50),
        .reset_n  (reset_n),
        .in_valid (out_valid),
        .in_data  (out_data),
        .in_ready (out_ready),
        .txd      (uart_txd)
    );

endmodule

// ==== tb/tb_sd_init.sv ====
// table-driven testbench for the SD bring-up top that decodes command frames and serial characters
`timescale 1ns/100ps
`include "sd_init_defs.svh"

module tb_sd_init;
    import sd_init_pkg::*;

    // fast dividers for simulation
    localparam int SD_HALF_TB = 4;
    localparam int BAUD_TB    = 16;
    localparam int CLK_PERIOD = 4;

    // ====================
    // run length and watchdog
    // ====================

    // idle clocks plus three frames at two half periods per sd_clk
    localparam int SD_CLOCKS    = (`SD_IDLE_CLOCKS + 3 * 48) * 2 * SD_HALF_TB;
    // four characters of ten bits each
    localparam int UART_CLOCKS  = 4 * 10 * BAUD_TB;
    localparam int RUN_CLOCKS   = SD_CLOCKS + UART_CLOCKS + 100;
    localparam int QUIET_CLOCKS = 20 * 10 * BAUD_TB;
    // doubled length of two runs, two quiet windows and the longest resets
    localparam int WATCHDOG_NS  =
        2 * (2 * RUN_CLOCKS + 2 * QUIET_CLOCKS + 16 + 40) * CLK_PERIOD;

    // expected command frames, in the order they leave
    typedef struct packed {
        sd_index_t    index;
        sd_arg_t      arg;
        status_char_t ch;
    } frame_row_t;

    localparam frame_row_t EXPECTED_ROWS [3] = '{
        '{SD_CMD0,   32'h0000_0000, "0"},
        '{SD_CMD55,  32'h0000_0000, "5"},
        '{SD_ACMD41, ACMD41_ARG,    "A"}
    };
    // closes the status stream
    localparam status_char_t DONE_CHAR = "D";

    logic CLOCK_50 = 1'b0;
    logic reset_n  = 1'b0;
    logic sd_clk;
    logic sd_cmd_out;
    logic sd_cmd_oe;
    logic uart_txd;
    logic init_done;

    // bits seen on rising sd_clk during one oe burst
    logic bit_q [$];
    int   hold;

    sd_init_top #(
        .SD_CLK_HALF_P (SD_HALF_TB),
        .BAUD_DIV_P    (BAUD_TB)
    ) UUT (
        .CLOCK_50   (CLOCK_50),
        .reset_n    (reset_n),
        .sd_clk     (sd_clk),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .uart_txd   (uart_txd),
        .init_done  (init_done)
    );

    always #2 CLOCK_50 = ~CLOCK_50;

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: bring-up sequence still running after %0d ns", WATCHDOG_NS);
        abort_run();
    end

    // ====================
    // checks
    // ====================

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_index(input string name, input sd_index_t got, input sd_index_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_arg(input string name, input sd_arg_t got, input sd_arg_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_crc(input string name, input crc7_t got, input crc7_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_char(input string name, input status_char_t got,
                              input status_char_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // reference crc7 over x^7 + x^3 + 1 sent msb first from zero
    function automatic crc7_t crc7_model(input logic [39:0] data);
        crc7_t c;
        logic  msb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            msb = c[6] ^ data[i];
            c   = {c[5:0], 1'b0};
            if (msb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    // ====================
    // stimulus and monitors
    // ====================

    // hold reset for the given cycles and check outputs while still in reset
    task automatic apply_reset(input int cycles);
        @(posedge CLOCK_50);
        reset_n <= 1'b0;
        repeat (cycles - 1) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        check_bit("sd_cmd_oe in reset", sd_cmd_oe, 1'b0);
        check_bit("sd_cmd_out in reset", sd_cmd_out, 1'b1);
        check_bit("sd_clk in reset", sd_clk, 1'b0);
        check_bit("uart_txd in reset", uart_txd, 1'b1);
        check_bit("init_done in reset", init_done, 1'b0);
        @(posedge CLOCK_50);
        reset_n <= 1'b1;
    endtask

    // collect one oe burst by sampling the line on each rising sd_clk
    task automatic capture_burst();
        logic prev_clk;
        bit_q.delete();
        @(negedge CLOCK_50);
        while (!sd_cmd_oe) begin
            // clock rests low between bursts
            check_bit("sd_clk while oe low", sd_clk, 1'b0);
            @(negedge CLOCK_50);
        end
        prev_clk = sd_clk;
        while (sd_cmd_oe) begin
            if (sd_clk && !prev_clk) begin
                bit_q.push_back(sd_cmd_out);
            end
            prev_clk = sd_clk;
            @(negedge CLOCK_50);
        end
    endtask

    // receive one 8N1 character sampled at mid-bit
    task automatic receive_char(output status_char_t ch);
        logic prev_txd;
        prev_txd = 1'b1;
        @(negedge CLOCK_50);
        while (!(prev_txd && !uart_txd)) begin
            prev_txd = uart_txd;
            @(negedge CLOCK_50);
        end
        repeat (BAUD_TB / 2 - 1) @(negedge CLOCK_50);
        check_bit("uart_txd start bit", uart_txd, 1'b0);
        for (int b = 0; b < 8; b++) begin
            repeat (BAUD_TB) @(negedge CLOCK_50);
            ch[b] = uart_txd;
        end
        repeat (BAUD_TB) @(negedge CLOCK_50);
        check_bit("uart_txd stop bit", uart_txd, 1'b1);
    endtask

    // idle clocks and frames on one side, status characters on the other
    task automatic run_sequence();
        fork
            begin
                logic [47:0] frame;
                capture_burst();
                check_count("idle sd_clk rises", bit_q.size(), `SD_IDLE_CLOCKS);
                foreach (bit_q[k]) begin
                    check_bit("sd_cmd_out idle", bit_q[k], 1'b1);
                end
                for (int r = 0; r < 3; r++) begin
                    capture_burst();
                    check_count("frame bit count", bit_q.size(), 48);
                    frame = '0;
                    foreach (bit_q[k]) begin
                        frame = {frame[46:0], bit_q[k]};
                    end
                    check_bit("frame start bit", frame[47], 1'b0);
                    check_bit("frame transmission bit", frame[46], 1'b1);
                    check_index("cmd_index", frame[45:40], EXPECTED_ROWS[r].index);
                    check_arg("cmd_arg", frame[39:8], EXPECTED_ROWS[r].arg);
                    check_crc("crc7", frame[7:1], crc7_model({1'b0, 1'b1,
                        EXPECTED_ROWS[r].index, EXPECTED_ROWS[r].arg}));
                    check_bit("frame end bit", frame[0], 1'b1);
                end
            end
            begin
                status_char_t ch;
                for (int c = 0; c < 4; c++) begin
                    receive_char(ch);
                    check_char("uart_txd char", ch,
                        (c < 3) ? EXPECTED_ROWS[c].ch : DONE_CHAR);
                end
            end
        join
    endtask

    // nothing moves once the sequence is done
    task automatic quiet_window();
        check_bit("init_done after run", init_done, 1'b1);
        repeat (QUIET_CLOCKS) begin
            @(negedge CLOCK_50);
            check_bit("sd_clk when done", sd_clk, 1'b0);
            check_bit("sd_cmd_oe when done", sd_cmd_oe, 1'b0);
            check_bit("uart_txd when done", uart_txd, 1'b1);
            check_bit("init_done when done", init_done, 1'b1);
        end
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin
        void'($urandom(46171));
        // CMD0 carries the well known 4A
        check_crc("crc7 model CMD0", crc7_model({2'b01, SD_CMD0, 32'h0}), 7'h4A);
        apply_reset(16);
        run_sequence();
        quiet_window();
        // second pass after a reset of random length
        hold = 16 + int'($urandom % 25);
        apply_reset(hold);
        run_sequence();
        quiet_window();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/sd_init_pkg.sv
logic/sd_cmd_tx.sv
logic/sd_init_seq.sv
logic/status_fifo.sv
logic/uart_tx.sv
logic/sd_init_top.sv
tb/tb_sd_init.sv

// ==== Makefile ====
# Verilator build and run for the SD bring-up testbench

TOP := tb_sd_init

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		-f project.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
